// File: vlog.f
verilog/game_pkg.sv
verilog/enemy_if.sv
verilog/game_fsm.sv
verilog/round_timer.sv
verilog/enemy_field.sv
verilog/collision_unit.sv
verilog/score_keeper.sv
verilog/game_core.sv
test/tb_game_core.sv

// File: Bender.yml
package:
  name: game_core

sources:
  - files:
      - verilog/game_pkg.sv
      - verilog/enemy_if.sv
      - verilog/game_fsm.sv
      - verilog/round_timer.sv
      - verilog/enemy_field.sv
      - verilog/collision_unit.sv
      - verilog/score_keeper.sv
      - verilog/game_core.sv
  - target: simulation
    files:
      - test/tb_game_core.sv

// File: test/tb_game_core.sv
`timescale 1ns/1ns

module tb_game_core import game_pkg::*; ();

    localparam int          CLK_PERIOD     = 20;
    localparam int unsigned RANDOM_SEED    = 32'hdd2f_c92f;
    // Four full rounds plus room for the button presses
    localparam int          TIMEOUT_CYCLES =
        4 * int'(ROUND_SECONDS) * int'(SEC_CYCLES + 1) + 1000;

    logic        clk;
    logic        reset;
    logic        start_btn;
    logic        player_detected;
    coord_t      player_x;
    game_state_t game_state;
    score_t      score;
    timer_t      timer_sec;
    logic        invincible;
    coord_t      enemy_x      [NUM_ENEMIES];
    coord_t      enemy_y      [NUM_ENEMIES];
    logic        enemy_active [NUM_ENEMIES];

    // Reference model, one sample behind the DUT
    game_state_t exp_state;
    game_state_t prev_state;
    score_t      prev_score;
    timer_t      prev_timer;
    logic        prev_inv;
    logic        prev2_inv;
    logic        prev_hit;
    logic        btn_prev;
    coord_t      prev_x      [NUM_ENEMIES];
    coord_t      prev_y      [NUM_ENEMIES];
    logic        prev_active [NUM_ENEMIES];
    int          pass_count;
    logic        detected_seen;  // Player seen at some point in this round
    int          inv_run;
    int          active_count;
    logic        crossed;
    logic        player_overlap;

    game_core game_core_inst (
        .clk             (clk),
        .reset           (reset),
        .start_btn       (start_btn),
        .player_detected (player_detected),
        .player_x        (player_x),
        .game_state      (game_state),
        .score           (score),
        .timer_sec       (timer_sec),
        .invincible      (invincible),
        .enemy_x         (enemy_x),
        .enemy_y         (enemy_y),
        .enemy_active    (enemy_active)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic game_state_t expected_next_state(game_state_t cur, logic pressed,
                                                        timer_t secs);
        case (cur)
            ST_WAIT:          return pressed ? ST_PLAY : ST_WAIT;
            ST_PLAY:          return (secs == 0) ? ST_FILTER_SELECT : ST_PLAY;  // Button ignored
            ST_FILTER_SELECT: return pressed ? ST_CAPTURE : ST_FILTER_SELECT;
            ST_CAPTURE:       return pressed ? ST_SEND : ST_CAPTURE;
            default:          return pressed ? ST_WAIT : ST_SEND;
        endcase
    endfunction

    function automatic int band_cap(timer_t secs);
        if (secs > BAND_MID_SEC) return CAP_SLOW;
        if (secs > BAND_FAST_SEC) return CAP_MID;
        return CAP_FAST;
    endfunction

    function automatic int saturate_score(int count);
        return (count > SCORE_MAX) ? SCORE_MAX : count;
    endfunction

    function automatic int after_hit(int points);
        return (points == 0) ? 0 : points - 1;  // Floor at zero
    endfunction

    // Two square boxes, each with its corner at (x, y)
    function automatic logic boxes_overlap(coord_t ax, coord_t ay, coord_t bx, coord_t by);
        int size;
        size = int'(PLANE_SIZE);
        return int'(ax) < int'(bx) + size && int'(bx) < int'(ax) + size &&
               int'(ay) < int'(by) + size && int'(by) < int'(ay) + size;
    endfunction

    // Follow the lowest enemy on screen
    function automatic coord_t chase_x();
        coord_t best_x;
        coord_t best_y;
        logic   found;
        best_x = coord_t'($urandom % SPAWN_X_RANGE);
        best_y = '0;
        found  = 1'b0;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (enemy_active[i] && (!found || enemy_y[i] > best_y)) begin
                best_x = enemy_x[i];
                best_y = enemy_y[i];
                found  = 1'b1;
            end
        end
        return best_x;
    endfunction

    task automatic report_error(input string test_name, input int expected, input int actual);
        $display("** Error [%s] expected %0d, actual %0d at %0t ns",
                 test_name, expected, actual, $time);
        $display("SIMULATION FAILED");
        $fatal(1, "Check %s failed", test_name);
    endtask

    always_comb begin
        active_count   = 0;
        crossed        = 1'b0;
        player_overlap = 1'b0;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (enemy_active[i]) active_count++;
            if (enemy_active[i] && prev_y[i] <= PLAYER_Y && enemy_y[i] > PLAYER_Y)
                crossed = 1'b1;  // Moved past the player row this cycle
            if (enemy_active[i] && boxes_overlap(player_x, PLAYER_Y, enemy_x[i], enemy_y[i]))
                player_overlap = 1'b1;
        end
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            exp_state     <= ST_WAIT;
            prev_state    <= ST_WAIT;
            prev_score    <= '0;
            prev_timer    <= ROUND_SECONDS;
            prev_inv      <= 1'b0;
            prev2_inv     <= 1'b0;
            prev_hit      <= 1'b0;
            btn_prev      <= 1'b0;
            pass_count    <= 0;
            detected_seen <= 1'b0;
            inv_run       <= 0;
            for (int i = 0; i < NUM_ENEMIES; i++) begin
                prev_x[i]      <= '0;
                prev_y[i]      <= '0;
                prev_active[i] <= 1'b0;
            end
        end else begin
            exp_state  <= expected_next_state(game_state, start_btn && !btn_prev, timer_sec);
            btn_prev   <= start_btn;
            prev_state <= game_state;
            prev_score <= score;
            prev_timer <= timer_sec;
            prev_inv   <= invincible;
            prev2_inv  <= prev_inv;
            prev_hit   <= (game_state == ST_PLAY) && player_detected && player_overlap;
            inv_run    <= invincible ? inv_run + 1 : 0;
            if (game_state == ST_WAIT) begin
                pass_count    <= 0;
                detected_seen <= 1'b0;
            end else if (game_state == ST_PLAY) begin
                if (player_detected) detected_seen <= 1'b1;
                if (crossed) pass_count <= pass_count + 1;
            end
            for (int i = 0; i < NUM_ENEMIES; i++) begin
                prev_x[i]      <= enemy_x[i];
                prev_y[i]      <= enemy_y[i];
                prev_active[i] <= enemy_active[i];
            end
        end
    end

    state_flow_check: assert property (@(posedge clk) disable iff (reset)
        game_state == exp_state)
        else report_error("state flow", $sampled(exp_state), $sampled(game_state));

    timer_step_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_PLAY && game_state == ST_PLAY |->
            timer_sec == prev_timer || int'(timer_sec) == int'(prev_timer) - 1)
        else report_error("timer step", $sampled(prev_timer), $sampled(timer_sec));

    band_cap_check: assert property (@(posedge clk) disable iff (reset)
        active_count <= band_cap(timer_sec))
        else report_error("enemy cap", band_cap($sampled(timer_sec)), $sampled(active_count));

    wait_clear_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_WAIT |-> active_count == 0)
        else report_error("enemies cleared in wait", 0, $sampled(active_count));

    pass_total_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_PLAY && game_state == ST_FILTER_SELECT && !detected_seen |->
            score == saturate_score(pass_count))
        else report_error("pass scoring", saturate_score($sampled(pass_count)), $sampled(score));

    // Invincibility starts exactly one cycle after a visible overlap
    hit_detect_check: assert property (@(posedge clk) disable iff (reset)
        !prev_inv |-> invincible == prev_hit)
        else report_error("collision detect", $sampled(prev_hit), $sampled(invincible));

    hit_penalty_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_PLAY && prev_inv && !prev2_inv |-> score == after_hit(prev_score))
        else report_error("hit penalty", after_hit($sampled(prev_score)), $sampled(score));

    loss_source_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_PLAY && score < prev_score |-> prev_inv && !prev2_inv)
        else report_error("score loss while invincible", 1, $sampled(prev_inv && !prev2_inv));

    inv_max_check: assert property (@(posedge clk) disable iff (reset)
        invincible |-> inv_run < INVINCIBLE_CYCLES)
        else report_error("invincible too long", INVINCIBLE_CYCLES, $sampled(inv_run) + 1);

    inv_length_check: assert property (@(posedge clk) disable iff (reset)
        !invincible && prev_inv && game_state == ST_PLAY |-> inv_run == INVINCIBLE_CYCLES)
        else report_error("invincible length", INVINCIBLE_CYCLES, $sampled(inv_run));

    score_hold_check: assert property (@(posedge clk) disable iff (reset)
        prev_state inside {ST_FILTER_SELECT, ST_CAPTURE, ST_SEND} |-> score == prev_score)
        else report_error("score hold", $sampled(prev_score), $sampled(score));

    score_clear_check: assert property (@(posedge clk) disable iff (reset)
        prev_state == ST_WAIT |-> score == 0)
        else report_error("score clear", 0, $sampled(score));

    for (genvar i = 0; i < NUM_ENEMIES; i++) begin : g_enemy_checks
        spawn_row_check: assert property (@(posedge clk) disable iff (reset)
            enemy_active[i] && !prev_active[i] |-> enemy_y[i] == 0)
            else report_error("spawn row", 0, $sampled(enemy_y[i]));

        x_range_check: assert property (@(posedge clk) disable iff (reset)
            enemy_active[i] |-> enemy_x[i] < SPAWN_X_RANGE)
            else report_error("enemy x below range", SPAWN_X_RANGE, $sampled(enemy_x[i]));

        y_even_check: assert property (@(posedge clk) disable iff (reset)
            enemy_active[i] |-> !enemy_y[i][0])
            else report_error("enemy y even", 0, $sampled(enemy_y[i][0]));

        frozen_x_check: assert property (@(posedge clk) disable iff (reset)
            prev_state inside {ST_FILTER_SELECT, ST_CAPTURE, ST_SEND} |-> enemy_x[i] == prev_x[i])
            else report_error("frozen enemy x", $sampled(prev_x[i]), $sampled(enemy_x[i]));

        frozen_y_check: assert property (@(posedge clk) disable iff (reset)
            prev_state inside {ST_FILTER_SELECT, ST_CAPTURE, ST_SEND} |-> enemy_y[i] == prev_y[i])
            else report_error("frozen enemy y", $sampled(prev_y[i]), $sampled(enemy_y[i]));

        frozen_active_check: assert property (@(posedge clk) disable iff (reset)
            prev_state inside {ST_FILTER_SELECT, ST_CAPTURE, ST_SEND} |->
                enemy_active[i] == prev_active[i])
            else report_error("frozen enemy flag", $sampled(prev_active[i]),
                              $sampled(enemy_active[i]));
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;  // Inputs change away from the edge
    endtask

    task automatic check_reset_values();
        assert (game_state == ST_WAIT) else report_error("reset state", ST_WAIT, game_state);
        assert (score == 0) else report_error("reset score", 0, score);
        assert (timer_sec == ROUND_SECONDS)
            else report_error("reset timer", ROUND_SECONDS, timer_sec);
        assert (!invincible) else report_error("reset invincible", 0, invincible);
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            assert (!enemy_active[i]) else report_error("reset enemy flag", 0, enemy_active[i]);
        end
    endtask

    task automatic press_start(input int hold_cycles);
        int gap;
        gap       = 1 + int'($urandom % 4);
        start_btn = 1'b1;
        repeat (hold_cycles) next_cycle();
        start_btn = 1'b0;
        repeat (gap) next_cycle();
    endtask

    // Runs until the round timer ends play
    task automatic play_round(input logic detected);
        player_detected = detected;
        while (game_state != ST_FILTER_SELECT) begin
            player_x = detected ? chase_x() : coord_t'($urandom % SPAWN_X_RANGE);
            next_cycle();
        end
        player_detected = 1'b0;
    endtask

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Run timed out after %0d cycles before the tests finished", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        clk             = 1'b0;
        reset           = 1'b1;
        start_btn       = 1'b0;
        player_detected = 1'b0;
        player_x        = '0;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        check_reset_values();

        press_start(3);
        play_round(1'b0);  // Passes only, no collisions
        press_start(4);    // Held press moves one state
        press_start(1);
        press_start(2);

        press_start(1);
        play_round(1'b1);  // Player chases enemies
        press_start(1);
        press_start(3);
        press_start(1);
        repeat (5) next_cycle();
        assert (game_state == ST_WAIT) else report_error("final state", ST_WAIT, game_state);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: verilog/game_core.sv
`timescale 1ns/1ns

module game_core import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_btn,
    input  logic        player_detected,
    input  coord_t      player_x,
    output game_state_t game_state,
    output score_t      score,
    output timer_t      timer_sec,
    output logic        invincible,
    output coord_t      enemy_x      [NUM_ENEMIES],
    output coord_t      enemy_y      [NUM_ENEMIES],
    output logic        enemy_active [NUM_ENEMIES]
);

    logic collision_event;

    enemy_if enemies ();  // Shared enemy state between peers

    game_fsm game_fsm_inst (
        .clk        (clk),
        .reset      (reset),
        .start_btn  (start_btn),
        .timer_sec  (timer_sec),
        .game_state (game_state)
    );

    round_timer round_timer_inst (
        .clk        (clk),
        .reset      (reset),
        .game_state (game_state),
        .timer_sec  (timer_sec)
    );

    enemy_field enemy_field_inst (
        .clk        (clk),
        .reset      (reset),
        .game_state (game_state),
        .timer_sec  (timer_sec),
        .enemies    (enemies.field)
    );

    collision_unit collision_unit_inst (
        .clk             (clk),
        .reset           (reset),
        .game_state      (game_state),
        .player_x        (player_x),
        .player_detected (player_detected),
        .enemies         (enemies.collider),
        .collision_event (collision_event),
        .invincible      (invincible)
    );

    score_keeper score_keeper_inst (
        .clk             (clk),
        .reset           (reset),
        .game_state      (game_state),
        .collision_event (collision_event),
        .enemies         (enemies.scorer),
        .score           (score)
    );

    assign enemy_x      = enemies.enemy_x;
    assign enemy_y      = enemies.enemy_y;
    assign enemy_active = enemies.enemy_active;

endmodule

// File: verilog/score_keeper.sv
`timescale 1ns/1ns

module score_keeper import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t game_state,
    input  logic        collision_event,
    enemy_if.scorer     enemies,
    output score_t      score
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else begin
            case (game_state)
                ST_WAIT: score <= '0;
                ST_PLAY: begin
                    // Hit wins over a pass in the same cycle
                    if (collision_event) begin
                        if (score != '0) score <= score - 1'b1;
                    end else if (enemies.pass_event) begin
                        if (score < SCORE_MAX) score <= score + 1'b1;  // Saturate
                    end
                end
                default: ;  // Kept for the result screens
            endcase
        end
    end

endmodule

// File: verilog/collision_unit.sv
`timescale 1ns/1ns

module collision_unit import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t game_state,
    input  coord_t      player_x,
    input  logic        player_detected,
    enemy_if.collider   enemies,
    output logic        collision_event,
    output logic        invincible
);

    logic [31:0]      inv_cnt;
    logic             hit;
    logic [COORD_W:0] px_lo, px_hi;  // One extra bit, no wrap at the edge
    logic [COORD_W:0] ex_lo, ex_hi, ey_lo, ey_hi;

    assign invincible = (inv_cnt != '0);

    // Box overlap against every active enemy
    always_comb begin
        hit   = 1'b0;
        px_lo = {1'b0, player_x};
        px_hi = px_lo + PLANE_SIZE;
        ex_lo = '0;
        ex_hi = '0;
        ey_lo = '0;
        ey_hi = '0;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            ex_lo = {1'b0, enemies.enemy_x[i]};
            ex_hi = ex_lo + PLANE_SIZE;
            ey_lo = {1'b0, enemies.enemy_y[i]};
            ey_hi = ey_lo + PLANE_SIZE;
            if (enemies.enemy_active[i] && px_hi > ex_lo && px_lo < ex_hi &&
                PLAYER_Y + PLANE_SIZE > ey_lo && PLAYER_Y < ey_hi)
                hit = 1'b1;
        end
        if (game_state != ST_PLAY || !player_detected) hit = 1'b0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inv_cnt         <= '0;
            collision_event <= 1'b0;
        end else begin
            collision_event <= 1'b0;
            if (game_state != ST_PLAY) begin
                inv_cnt <= '0;
            end else if (hit && inv_cnt == '0) begin
                collision_event <= 1'b1;
                inv_cnt         <= INVINCIBLE_CYCLES;  // Grace period after a hit
            end else if (inv_cnt != '0) begin
                inv_cnt <= inv_cnt - 1'b1;
            end
        end
    end

endmodule

// File: verilog/enemy_field.sv
`timescale 1ns/1ns

module enemy_field import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t game_state,
    input  timer_t      timer_sec,
    enemy_if.field      enemies
);

    logic [31:0]                    move_cnt;
    logic [31:0]                    spawn_cnt;
    logic [31:0]                    spawn_interval;
    logic [CNT_W-1:0]               enemy_cap;
    logic [CNT_W-1:0]               active_cnt;
    logic [15:0]                    lfsr;
    logic [$clog2(NUM_ENEMIES)-1:0] spawn_idx;
    logic                           spawn_try;
    coord_t                         next_y [NUM_ENEMIES];

    // Number of enemies on the field
    always_comb begin
        active_cnt = '0;
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            if (enemies.enemy_active[i]) active_cnt = active_cnt + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_ENEMIES; i++) begin
            next_y[i] = enemies.enemy_y[i] + FALL_STEP;
        end
    end

    assign spawn_try = (spawn_cnt >= spawn_interval) && (active_cnt < enemy_cap);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            move_cnt           <= '0;
            spawn_cnt          <= '0;
            spawn_interval     <= SPAWN_SLOW;
            enemy_cap          <= CAP_SLOW;
            lfsr               <= LFSR_SEED;
            spawn_idx          <= '0;
            enemies.pass_event <= 1'b0;
            for (int i = 0; i < NUM_ENEMIES; i++) begin
                enemies.enemy_x[i]      <= '0;
                enemies.enemy_y[i]      <= '0;
                enemies.enemy_active[i] <= 1'b0;
            end
        end else begin
            enemies.pass_event <= 1'b0;
            case (game_state)
                ST_WAIT: begin
                    move_cnt       <= '0;
                    spawn_cnt      <= '0;
                    spawn_interval <= SPAWN_SLOW;
                    enemy_cap      <= CAP_SLOW;
                    for (int i = 0; i < NUM_ENEMIES; i++) begin
                        enemies.enemy_active[i] <= 1'b0;
                        enemies.enemy_y[i]      <= '0;
                    end
                end
                ST_PLAY: begin
                    // Faster spawns and more enemies late in the round
                    if (timer_sec > BAND_MID_SEC) begin
                        spawn_interval <= SPAWN_SLOW;
                        enemy_cap      <= CAP_SLOW;
                    end else if (timer_sec > BAND_FAST_SEC) begin
                        spawn_interval <= SPAWN_MID;
                        enemy_cap      <= CAP_MID;
                    end else begin
                        spawn_interval <= SPAWN_FAST;
                        enemy_cap      <= CAP_FAST;
                    end

                    if (move_cnt >= MOVE_CYCLES) begin
                        move_cnt <= '0;
                        for (int i = 0; i < NUM_ENEMIES; i++) begin
                            if (enemies.enemy_active[i]) begin
                                enemies.enemy_y[i] <= next_y[i];
                                if (enemies.enemy_y[i] <= PLAYER_Y && next_y[i] > PLAYER_Y)
                                    enemies.pass_event <= 1'b1;  // Shows with the new y
                                if (next_y[i] > FIELD_BOTTOM)
                                    enemies.enemy_active[i] <= 1'b0;
                            end
                        end
                    end else begin
                        move_cnt <= move_cnt + 1'b1;
                    end

                    if (spawn_try) begin
                        spawn_cnt <= '0;
                        lfsr      <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
                        // Busy slot skips this attempt
                        if (!enemies.enemy_active[spawn_idx]) begin
                            enemies.enemy_active[spawn_idx] <= 1'b1;
                            enemies.enemy_x[spawn_idx]      <= lfsr[8:0] % SPAWN_X_RANGE;
                            enemies.enemy_y[spawn_idx]      <= '0;
                        end
                        spawn_idx <= spawn_idx + 1'b1;
                    end else begin
                        spawn_cnt <= spawn_cnt + 1'b1;
                    end
                end
                default: ;  // Field frozen
            endcase
        end
    end

endmodule

// File: verilog/round_timer.sv
`timescale 1ns/1ns

module round_timer import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  game_state_t game_state,
    output timer_t      timer_sec
);

    logic [31:0] cycle_cnt;  // Cycles within the current game second

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cycle_cnt <= '0;
            timer_sec <= ROUND_SECONDS;
        end else begin
            case (game_state)
                ST_WAIT: begin
                    cycle_cnt <= '0;
                    timer_sec <= ROUND_SECONDS;
                end
                ST_PLAY: begin
                    if (cycle_cnt >= SEC_CYCLES) begin
                        cycle_cnt <= '0;
                        if (timer_sec != '0) timer_sec <= timer_sec - 1'b1;  // Stops at 0
                    end else begin
                        cycle_cnt <= cycle_cnt + 1'b1;
                    end
                end
                default: ;  // Frozen after the round
            endcase
        end
    end

endmodule

// File: verilog/game_fsm.sv
`timescale 1ns/1ns

module game_fsm import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_btn,
    input  timer_t      timer_sec,
    output game_state_t game_state
);

    logic start_btn_prev;
    logic start_edge;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_btn_prev <= 1'b0;
        end else begin
            start_btn_prev <= start_btn;
        end
    end

    assign start_edge = start_btn & ~start_btn_prev;  // Held button counts once

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            game_state <= ST_WAIT;
        end else begin
            case (game_state)
                ST_WAIT:          if (start_edge) game_state <= ST_PLAY;
                // Button ignored, round ends on the timer
                ST_PLAY:          if (timer_sec == '0) game_state <= ST_FILTER_SELECT;
                ST_FILTER_SELECT: if (start_edge) game_state <= ST_CAPTURE;
                ST_CAPTURE:       if (start_edge) game_state <= ST_SEND;
                ST_SEND:          if (start_edge) game_state <= ST_WAIT;
                default:          game_state <= ST_WAIT;
            endcase
        end
    end

endmodule

// File: verilog/enemy_if.sv
`timescale 1ns/1ns

interface enemy_if import game_pkg::*; ();

    coord_t enemy_x      [NUM_ENEMIES];
    coord_t enemy_y      [NUM_ENEMIES];
    logic   enemy_active [NUM_ENEMIES];
    logic   pass_event;  // One cycle, some enemy crossed the player row

    modport field (
        output enemy_x, enemy_y, enemy_active, pass_event
    );

    modport collider (
        input enemy_x, enemy_y, enemy_active
    );

    modport scorer (
        input pass_event
    );

endinterface

// File: verilog/game_pkg.sv
package game_pkg;

    // Top-level game flow
    typedef enum logic [2:0] {
        ST_WAIT          = 3'd0,
        ST_PLAY          = 3'd1,
        ST_FILTER_SELECT = 3'd2,
        ST_CAPTURE       = 3'd3,
        ST_SEND          = 3'd4
    } game_state_t;

    localparam int NUM_ENEMIES = 8;
    localparam int CNT_W       = $clog2(NUM_ENEMIES + 1);  // Holds 0..NUM_ENEMIES

    localparam int COORD_W = 9;
    typedef logic [COORD_W-1:0] coord_t;

    localparam int SCORE_W = 10;
    typedef logic [SCORE_W-1:0] score_t;
    localparam score_t SCORE_MAX = 10'd999;

    localparam int TIMER_W = 6;
    typedef logic [TIMER_W-1:0] timer_t;
    localparam timer_t ROUND_SECONDS = 6'd30;

    // 25_000_000 on the board, scaled down for simulation
    localparam logic [31:0] SEC_CYCLES  = 32'd16;
    localparam logic [31:0] MOVE_CYCLES = 32'd4;

    localparam coord_t FALL_STEP     = 9'd2;
    localparam coord_t FIELD_BOTTOM  = 9'd240;
    localparam coord_t SPAWN_X_RANGE = 9'd305;
    localparam logic [15:0] LFSR_SEED = 16'hACE1;

    // Difficulty bands
    localparam logic [31:0] SPAWN_SLOW = SEC_CYCLES;
    localparam logic [31:0] SPAWN_MID  = SEC_CYCLES / 2;
    localparam logic [31:0] SPAWN_FAST = SEC_CYCLES / 3;
    localparam logic [CNT_W-1:0] CAP_SLOW = 4'd3;
    localparam logic [CNT_W-1:0] CAP_MID  = 4'd5;
    localparam logic [CNT_W-1:0] CAP_FAST = 4'd8;
    localparam timer_t BAND_MID_SEC  = 6'd20;
    localparam timer_t BAND_FAST_SEC = 6'd10;

    localparam coord_t PLAYER_Y   = 9'd210;
    localparam coord_t PLANE_SIZE = 9'd16;
    localparam logic [31:0] INVINCIBLE_CYCLES = SEC_CYCLES;

endpackage
